/* tests/scoreboard_input.txt */
# test cmd a b c d e f (hex) | issue: rd fu ack id full | wb: id data rs1 v1 rs1_data cvalid
# commit: rd result id full | read: rs1 rs2 v1 d1 v2 d2 | flush: full cvalid id clob | check_clobber: reg fu
fill issue 1 1 1 0 0 0
fill issue 2 1 1 1 0 0
fill issue 3 2 1 2 0 0
fill issue 4 3 1 3 0 0
fill issue 5 2 1 4 0 0
fill issue 9 3 1 5 0 0
fill issue 0 4 1 6 1 0
fill issue a 1 0 7 1 0
order wb 2 33 3 1 33 0
order wb 0 11 0 0 0 1
order wb 1 22 0 0 0 1
order commit 1 11 0 0 0 0
order commit 2 22 1 0 0 0
order commit 3 33 2 0 0 0
fwd wb 3 deadbeef 4 1 deadbeef 1
fwd read 9 4 0 0 1 deadbeef
fwd read 0 0 0 0 0 0
clob check_clobber 5 2 0 0 0 0
clob check_clobber 9 3 0 0 0 0
clob check_clobber 0 0 0 0 0 0
clob check_clobber 1 0 0 0 0 0
clob commit 4 deadbeef 3 0 0 0
clob wb 4 55 5 1 55 1
clob wb 5 99 9 1 99 1
clob commit 5 55 4 0 0 0
clob commit 9 99 5 0 0 0
clob check_clobber 5 0 0 0 0 0
clob check_clobber 9 0 0 0 0 0
flush issue 7 1 1 7 0 0
flush flush 0 0 0 0 0 0
flush wb 7 77 0 0 0 0
flush read 7 7 0 0 0 0
fu_none issue 8 0 1 0 0 0
fu_none commit 8 0 0 0 0 0

/* sim.f */
+incdir+hw
hw/isa_pkg.sv
hw/sb_pkg.sv
hw/sb_ctrl_if.sv
hw/prio_select.sv
hw/sb_alloc.sv
hw/sb_entries.sv
hw/sb_clobber.sv
hw/sb_forward.sv
hw/scoreboard_top.sv
tests/tb_scoreboard.sv

/* Makefile */
# Verilator build and run of the scoreboard testbench
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module tb_scoreboard -Mdir obj_dir

run: build
	./obj_dir/Vtb_scoreboard | tee $(LOG)
	grep -q "All checks passed" $(LOG)

lint:
	verilator --lint-only --timing -f sim.f --top-module tb_scoreboard

clean:
	rm -rf obj_dir $(LOG)

/* tests/tb_scoreboard.sv */
/*
  testbench for scoreboard_top driven by tests/scoreboard_input.txt
  each line is one command with six hex operands that include the expected values
  inputs change 1 ns after the rising edge and outputs are sampled at the falling edge
*/
`include "sb_consts.svh"

module tb_scoreboard
  import isa_pkg::*;
  import sb_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NrRegs     = 1 << `SB_REG_ADDR_BITS;
  localparam int WaitCycles = 20;

  logic clk_i;
  logic rst_ni;
  logic flush_i;
  logic decoded_valid_i;
  reg_addr_t decoded_rd_i;
  fu_t decoded_fu_i;
  logic decoded_ack_o;
  trans_id_t issue_trans_id_o;
  logic sb_full_o;
  logic wb_valid_i;
  trans_id_t wb_trans_id_i;
  xlen_t wb_data_i;
  logic commit_valid_o;
  reg_addr_t commit_rd_o;
  xlen_t commit_result_o;
  trans_id_t commit_trans_id_o;
  logic commit_ack_i;
  reg_addr_t rs1_i;
  xlen_t rs1_o;
  logic rs1_valid_o;
  reg_addr_t rs2_i;
  xlen_t rs2_o;
  logic rs2_valid_o;
  fu_t [NrRegs-1:0] rd_clobber_o;

  // current command and bookkeeping
  logic [8*16-1:0] cur_test;
  logic [8*16-1:0] cmd;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] op_c;
  logic [31:0] op_d;
  logic [31:0] op_e;
  logic [31:0] op_f;
  int test_errs;
  int tests_pass;
  int tests_fail;
  logic timed_out;
  logic setup_failed;

  scoreboard_top DUT (.*);

  always #5 clk_i = ~clk_i;

  // --------------------
  // helpers
  // --------------------
  task automatic check_val(input string sig, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[ERROR] t=%0t %s expected 0x%0h actual 0x%0h", $time, sig, exp, act);
      test_errs++;
    end
  endtask

  // inputs may change from here on
  task automatic next_drive_point();
    @(posedge clk_i);
    #1;
  endtask

  // one clock edge with the strobes applied, then drop them
  task automatic close_cycle();
    next_drive_point();
    decoded_valid_i = 1'b0;
    wb_valid_i      = 1'b0;
    commit_ack_i    = 1'b0;
    flush_i         = 1'b0;
  endtask

  task automatic report_test();
    if (cur_test != '0) begin
      if (test_errs == 0) begin
        $display("test %0s: PASS", cur_test);
        tests_pass++;
      end else begin
        $display("test %0s: FAIL (%0d errors)", cur_test, test_errs);
        tests_fail++;
      end
    end
    test_errs = 0;
  endtask

  // --------------------
  // commands
  // --------------------
  task automatic issue_instr();
    next_drive_point();
    decoded_valid_i = 1'b1;
    decoded_rd_i    = reg_addr_t'(op_a);
    decoded_fu_i    = fu_t'(op_b[2:0]);
    @(negedge clk_i);
    check_val("decoded_ack_o", op_c, 32'(decoded_ack_o));
    check_val("issue_trans_id_o", op_d, 32'(issue_trans_id_o));
    close_cycle();
    @(negedge clk_i);
    check_val("sb_full_o", op_e, 32'(sb_full_o));
  endtask

  task automatic write_back();
    next_drive_point();
    wb_valid_i    = 1'b1;
    wb_trans_id_i = trans_id_t'(op_a);
    wb_data_i     = op_b;
    rs1_i         = reg_addr_t'(op_c);
    // forwarded from the port in the same cycle
    @(negedge clk_i);
    check_val("rs1_valid_o", op_d, 32'(rs1_valid_o));
    if (op_d != 0) check_val("rs1_o", op_e, rs1_o);
    close_cycle();
    @(negedge clk_i);
    check_val("commit_valid_o", op_f, 32'(commit_valid_o));
  endtask

  task automatic commit_head();
    int waited;
    next_drive_point();
    waited = 0;
    @(negedge clk_i);
    while (!commit_valid_o && waited < WaitCycles) begin
      @(negedge clk_i);
      waited++;
    end
    if (!commit_valid_o) begin
      $display("timeout in test %0s: commit_valid_o stayed low for %0d cycles",
               cur_test, WaitCycles);
      timed_out = 1'b1;
      test_errs++;
    end else begin
      check_val("commit_rd_o", op_a, 32'(commit_rd_o));
      check_val("commit_result_o", op_b, commit_result_o);
      check_val("commit_trans_id_o", op_c, 32'(commit_trans_id_o));
      next_drive_point();
      commit_ack_i = 1'b1;
      close_cycle();
      @(negedge clk_i);
      check_val("sb_full_o", op_d, 32'(sb_full_o));
    end
  endtask

  task automatic flush_all();
    next_drive_point();
    flush_i = 1'b1;
    close_cycle();
    @(negedge clk_i);
    check_val("sb_full_o", op_a, 32'(sb_full_o));
    check_val("commit_valid_o", op_b, 32'(commit_valid_o));
    check_val("issue_trans_id_o", op_c, 32'(issue_trans_id_o));
    // whole table including x0
    for (int r = 0; r < NrRegs; r++) begin
      check_val($sformatf("rd_clobber_o[%0d]", r), op_d, 32'(rd_clobber_o[r]));
    end
  endtask

  task automatic read_operands();
    next_drive_point();
    rs1_i = reg_addr_t'(op_a);
    rs2_i = reg_addr_t'(op_b);
    @(negedge clk_i);
    // data only compared when a hit is expected
    check_val("rs1_valid_o", op_c, 32'(rs1_valid_o));
    if (op_c != 0) check_val("rs1_o", op_d, rs1_o);
    check_val("rs2_valid_o", op_e, 32'(rs2_valid_o));
    if (op_e != 0) check_val("rs2_o", op_f, rs2_o);
  endtask

  task automatic inspect_clobber();
    next_drive_point();
    @(negedge clk_i);
    check_val($sformatf("rd_clobber_o[%0d]", op_a[`SB_REG_ADDR_BITS-1:0]), op_b,
              32'(rd_clobber_o[op_a[`SB_REG_ADDR_BITS-1:0]]));
  endtask

  task automatic run_command();
    if (cmd == 128'("issue")) issue_instr();
    else if (cmd == 128'("wb")) write_back();
    else if (cmd == 128'("commit")) commit_head();
    else if (cmd == 128'("flush")) flush_all();
    else if (cmd == 128'("read")) read_operands();
    else if (cmd == 128'("check_clobber")) inspect_clobber();
    else begin
      $display("unknown command %0s in test %0s", cmd, cur_test);
      test_errs++;
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin : stimulus
    int fd;
    int code;
    logic reading;
    logic [8*16-1:0] tok;
    logic [8*256-1:0] skip_line;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    decoded_valid_i = 1'b0;
    decoded_rd_i = '0;
    decoded_fu_i = FU_NONE;
    wb_valid_i = 1'b0;
    wb_trans_id_i = '0;
    wb_data_i = '0;
    commit_ack_i = 1'b0;
    rs1_i = '0;
    rs2_i = '0;
    cur_test = '0;
    test_errs = 0;
    tests_pass = 0;
    tests_fail = 0;
    timed_out = 1'b0;
    setup_failed = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    fd = $fopen("tests/scoreboard_input.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/scoreboard_input.txt");
      setup_failed = 1'b1;
    end else begin
      reading = 1'b1;
      while (reading && !timed_out) begin
        code = $fscanf(fd, "%s", tok);
        if (code != 1) begin
          reading = 1'b0;
        end else if (tok == 128'("#")) begin
          code = $fgets(skip_line, fd);
        end else begin
          code = $fscanf(fd, "%s %h %h %h %h %h %h", cmd, op_a, op_b, op_c, op_d, op_e, op_f);
          if (code != 7) begin
            $display("malformed stimulus line in test %0s", tok);
            setup_failed = 1'b1;
            reading = 1'b0;
          end else begin
            // a new name closes the previous test
            if (tok != cur_test) begin
              report_test();
              cur_test = tok;
            end
            run_command();
          end
        end
      end
      $fclose(fd);
    end
    report_test();

    $display("tests passed %0d, tests failed %0d", tests_pass, tests_fail);
    if (tests_fail == 0 && tests_pass > 0 && !timed_out && !setup_failed) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* hw/scoreboard_top.sv */
/*
  instruction scoreboard, in-order issue and commit, out-of-order write-back
  one write-back port and one commit port
  the decoder holds its inputs while decoded_ack_o is low
  all read-side outputs are combinational from the entries and the write-back port
*/
`include "sb_consts.svh"

module scoreboard_top
  import isa_pkg::*;
  import sb_pkg::*;
(
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  // issue side
  input  logic                                   decoded_valid_i,
  input  reg_addr_t                              decoded_rd_i,
  input  fu_t                                    decoded_fu_i,
  output logic                                   decoded_ack_o,
  output trans_id_t                              issue_trans_id_o,
  output logic                                   sb_full_o,
  // write-back strobe
  input  logic                                   wb_valid_i,
  input  trans_id_t                              wb_trans_id_i,
  input  xlen_t                                  wb_data_i,
  // head of the ring
  output logic                                   commit_valid_o,
  output reg_addr_t                              commit_rd_o,
  output xlen_t                                  commit_result_o,
  output trans_id_t                              commit_trans_id_o,
  input  logic                                   commit_ack_i,
  // operand read
  input  reg_addr_t                              rs1_i,
  output xlen_t                                  rs1_o,
  output logic                                   rs1_valid_o,
  input  reg_addr_t                              rs2_i,
  output xlen_t                                  rs2_o,
  output logic                                   rs2_valid_o,
  // pending writer per register
  output fu_t [(1 << `SB_REG_ADDR_BITS)-1:0]     rd_clobber_o
);

  sb_entry_t [`SB_NR_ENTRIES-1:0] entries;

  sb_ctrl_if #(
    .id_t      (trans_id_t),
    .rd_t      (reg_addr_t),
    .fu_code_t (fu_t)
  ) ctrl_if ();

  // --------------------
  // pointers and store
  // --------------------
  sb_alloc i_alloc (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .decoded_valid_i  (decoded_valid_i),
    .decoded_rd_i     (decoded_rd_i),
    .decoded_fu_i     (decoded_fu_i),
    .commit_ack_i     (commit_ack_i),
    .decoded_ack_o    (decoded_ack_o),
    .issue_trans_id_o (issue_trans_id_o),
    .sb_full_o        (sb_full_o),
    .commit_id_o      (commit_trans_id_o),
    .ctrl_o           (ctrl_if.ctrl)
  );

  sb_entries i_entries (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .wb_valid_i      (wb_valid_i),
    .wb_trans_id_i   (wb_trans_id_i),
    .wb_data_i       (wb_data_i),
    .ctrl_i          (ctrl_if.store),
    .entries_o       (entries),
    .commit_valid_o  (commit_valid_o),
    .commit_rd_o     (commit_rd_o),
    .commit_result_o (commit_result_o)
  );

  // --------------------
  // read side
  // --------------------
  sb_clobber i_clobber (
    .entries_i    (entries),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_forward i_forward (
    .entries_i     (entries),
    .wb_valid_i    (wb_valid_i),
    .wb_trans_id_i (wb_trans_id_i),
    .wb_data_i     (wb_data_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .rs1_o         (rs1_o),
    .rs1_valid_o   (rs1_valid_o),
    .rs2_o         (rs2_o),
    .rs2_valid_o   (rs2_valid_o)
  );

endmodule

/* hw/sb_forward.sv */
/*
  operand forwarding for rs1 and rs2
  the write-back port has priority over finished entries
  reads of register 0 are never valid
*/
`include "sb_consts.svh"

module sb_forward
  import isa_pkg::*;
  import sb_pkg::*;
(
  input  sb_entry_t [`SB_NR_ENTRIES-1:0] entries_i,
  input  logic                           wb_valid_i,
  input  trans_id_t                      wb_trans_id_i,
  input  xlen_t                          wb_data_i,
  input  reg_addr_t                      rs1_i,
  input  reg_addr_t                      rs2_i,
  output xlen_t                          rs1_o,
  output logic                           rs1_valid_o,
  output xlen_t                          rs2_o,
  output logic                           rs2_valid_o
);

  // requester 0 is the write-back port, entries follow
  localparam int unsigned NrReq = `SB_NR_ENTRIES + 1;

  logic  [NrReq-1:0] rs1_req;
  logic  [NrReq-1:0] rs2_req;
  xlen_t [NrReq-1:0] fwd_data;
  logic              rs1_hit;
  logic              rs2_hit;

  // --------------------
  // request vectors
  // --------------------
  // result on the port this cycle, rd taken from its target entry
  assign rs1_req[0]  = wb_valid_i && (entries_i[wb_trans_id_i].rd == rs1_i);
  assign rs2_req[0]  = wb_valid_i && (entries_i[wb_trans_id_i].rd == rs2_i);
  assign fwd_data[0] = wb_data_i;

  // finished entries still waiting for commit
  for (genvar k = 0; k < `SB_NR_ENTRIES; k++) begin : gen_entry_req
    assign rs1_req[k+1]  = entries_i[k].issued && entries_i[k].done &&
                           (entries_i[k].rd == rs1_i);
    assign rs2_req[k+1]  = entries_i[k].issued && entries_i[k].done &&
                           (entries_i[k].rd == rs2_i);
    assign fwd_data[k+1] = entries_i[k].result;
  end

  // --------------------
  // data selection
  // --------------------
  prio_select #(
    .N         (NrReq),
    .payload_t (xlen_t),
    .DEFAULT   ('0)
  ) i_sel_rs1 (
    .req_i   (rs1_req),
    .data_i  (fwd_data),
    .valid_o (rs1_hit),
    .data_o  (rs1_o)
  );

  prio_select #(
    .N         (NrReq),
    .payload_t (xlen_t),
    .DEFAULT   ('0)
  ) i_sel_rs2 (
    .req_i   (rs2_req),
    .data_i  (fwd_data),
    .valid_o (rs2_hit),
    .data_o  (rs2_o)
  );

  // x0 reads from the register file, never from here
  assign rs1_valid_o = rs1_hit && (|rs1_i);
  assign rs2_valid_o = rs2_hit && (|rs2_i);

endmodule

/* hw/sb_clobber.sv */
/*
  per-register clobber table
  shows the unit of the lowest-index issued entry that writes each register
  register 0 is never clobbered
*/
`include "sb_consts.svh"

module sb_clobber
  import isa_pkg::*;
  import sb_pkg::*;
(
  input  sb_entry_t [`SB_NR_ENTRIES-1:0]          entries_i,
  output fu_t       [(1 << `SB_REG_ADDR_BITS)-1:0] rd_clobber_o
);

  localparam int unsigned NrRegs = 1 << `SB_REG_ADDR_BITS;

  // unit code of every entry, shared by all selectors
  fu_t [`SB_NR_ENTRIES-1:0] entry_fu;

  for (genvar k = 0; k < `SB_NR_ENTRIES; k++) begin : gen_entry_fu
    assign entry_fu[k] = entries_i[k].fu;
  end

  // x0 always free
  assign rd_clobber_o[0] = FU_NONE;

  // --------------------
  // one selector per reg
  // --------------------
  for (genvar r = 1; r < NrRegs; r++) begin : gen_reg
    logic [`SB_NR_ENTRIES-1:0] pend_req;

    // live entries naming this register as destination
    for (genvar k = 0; k < `SB_NR_ENTRIES; k++) begin : gen_req
      assign pend_req[k] = entries_i[k].issued && (entries_i[k].rd == reg_addr_t'(r));
    end

    prio_select #(
      .N         (`SB_NR_ENTRIES),
      .payload_t (fu_t),
      .DEFAULT   (FU_NONE)
    ) i_sel_fu (
      .req_i   (pend_req),
      .data_i  (entry_fu),
      .valid_o (),
      .data_o  (rd_clobber_o[r])
    );
  end

endmodule

/* hw/sb_entries.sv */
/*
  entry store of the scoreboard ring
  a write-back to an entry that is not issued is dropped, e.g. after a flush
  flush wins over every other update in the same cycle
*/
`include "sb_consts.svh"

module sb_entries
  import isa_pkg::*;
  import sb_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               flush_i,
  input  logic                               wb_valid_i,
  input  trans_id_t                          wb_trans_id_i,
  input  xlen_t                              wb_data_i,
  sb_ctrl_if.store                           ctrl_i,
  output sb_entry_t [`SB_NR_ENTRIES-1:0]     entries_o,
  output logic                               commit_valid_o,
  output reg_addr_t                          commit_rd_o,
  output xlen_t                              commit_result_o
);

  sb_entry_t [`SB_NR_ENTRIES-1:0] mem_q;
  sb_entry_t [`SB_NR_ENTRIES-1:0] mem_n;

  always_comb begin : entry_update
    mem_n = mem_q;

    // --------------------
    // allocate
    // --------------------
    if (ctrl_i.alloc_en) begin
      mem_n[ctrl_i.alloc_id].issued = 1'b1;
      mem_n[ctrl_i.alloc_id].done   = 1'b0;
      mem_n[ctrl_i.alloc_id].rd     = ctrl_i.alloc_rd;
      mem_n[ctrl_i.alloc_id].fu     = ctrl_i.alloc_fu;
      mem_n[ctrl_i.alloc_id].result = '0;
    end

    // no unit to wait for, done one edge after issue
    for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
      if (mem_q[i].issued && (mem_q[i].fu == FU_NONE)) begin
        mem_n[i].done = 1'b1;
      end
    end

    // --------------------
    // write-back
    // --------------------
    // checked against the current issued bit, stale results are lost
    if (wb_valid_i && mem_q[wb_trans_id_i].issued) begin
      mem_n[wb_trans_id_i].done   = 1'b1;
      mem_n[wb_trans_id_i].result = wb_data_i;
    end

    // retire the head
    if (ctrl_i.commit_en) begin
      mem_n[ctrl_i.commit_id].issued = 1'b0;
      mem_n[ctrl_i.commit_id].done   = 1'b0;
    end

    // --------------------
    // flush
    // --------------------
    if (flush_i) begin
      for (int i = 0; i < `SB_NR_ENTRIES; i++) begin
        mem_n[i].issued = 1'b0;
        mem_n[i].done   = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else begin
      mem_q <= mem_n;
    end
  end

  // head entry shown to the commit stage
  assign commit_valid_o  = mem_q[ctrl_i.commit_id].done;
  assign commit_rd_o     = mem_q[ctrl_i.commit_id].rd;
  assign commit_result_o = mem_q[ctrl_i.commit_id].result;

  assign entries_o = mem_q;

endmodule

/* hw/sb_alloc.sv */
/*
  issue and commit pointers with the occupancy count
  full is raised at NR_ENTRIES-1 held entries, one slot always stays empty
  commit_ack_i must only be given while the head entry is done
*/
`include "sb_consts.svh"

module sb_alloc
  import isa_pkg::*;
  import sb_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,
  input  logic            decoded_valid_i,
  input  reg_addr_t       decoded_rd_i,
  input  fu_t             decoded_fu_i,
  input  logic            commit_ack_i,
  output logic            decoded_ack_o,
  output trans_id_t       issue_trans_id_o,
  output logic            sb_full_o,
  output trans_id_t       commit_id_o,
  sb_ctrl_if.ctrl         ctrl_o
);

  trans_id_t issue_ptr_q;
  trans_id_t commit_ptr_q;
  // held entries, never exceeds NR_ENTRIES-1 so the index width suffices
  trans_id_t count_q;
  logic      issue_en;

  // --------------------
  // issue acceptance
  // --------------------
  assign sb_full_o        = (count_q == trans_id_t'(`SB_NR_ENTRIES - 1));
  assign decoded_ack_o    = decoded_valid_i & ~sb_full_o;
  assign issue_en         = decoded_ack_o;
  assign issue_trans_id_o = issue_ptr_q;
  assign commit_id_o      = commit_ptr_q;

  // commands to the entry store
  assign ctrl_o.alloc_en  = issue_en;
  assign ctrl_o.alloc_id  = issue_ptr_q;
  assign ctrl_o.alloc_rd  = decoded_rd_i;
  assign ctrl_o.alloc_fu  = decoded_fu_i;
  assign ctrl_o.commit_en = commit_ack_i;
  assign ctrl_o.commit_id = commit_ptr_q;

  // --------------------
  // pointer registers
  // --------------------
  // pointers wrap by overflow, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      count_q      <= '0;
    end else if (flush_i) begin
      // flush drops everything, including an issue in this cycle
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      count_q      <= '0;
    end else begin
      issue_ptr_q  <= issue_ptr_q + trans_id_t'(issue_en);
      commit_ptr_q <= commit_ptr_q + trans_id_t'(commit_ack_i);
      // issue and commit in one cycle leave the count unchanged
      count_q      <= count_q + trans_id_t'(issue_en) - trans_id_t'(commit_ack_i);
    end
  end

endmodule

/* hw/prio_select.sv */
/*
  fixed-priority selector, lowest requesting index wins
  purely combinational, payload_t must be a packed type
*/
module prio_select #(
  parameter int unsigned N         = 2,
  parameter type         payload_t = logic,
  parameter payload_t    DEFAULT   = payload_t'(0)
) (
  input  logic     [N-1:0] req_i,
  input  payload_t [N-1:0] data_i,
  output logic             valid_o,
  output payload_t         data_o
);

  // scan from the top so the lowest index is written last
  always_comb begin
    valid_o = 1'b0;
    data_o  = DEFAULT;
    for (int i = N - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        valid_o = 1'b1;
        data_o  = data_i[i];
      end
    end
  end

endmodule

/* hw/sb_ctrl_if.sv */
/*
  allocation and retirement commands from the pointer logic to the entry store
  payload types are set by the instantiating level
  commands are single-cycle strobes, applied at the next clock edge
*/
interface sb_ctrl_if #(
  parameter type id_t      = logic,
  parameter type rd_t      = logic,
  parameter type fu_code_t = logic
) ();

  // allocate one entry at alloc_id
  logic     alloc_en;
  id_t      alloc_id;
  rd_t      alloc_rd;
  fu_code_t alloc_fu;

  // retire the head entry, commit_id is also the current head index
  logic     commit_en;
  id_t      commit_id;

  modport ctrl (
    output alloc_en, alloc_id, alloc_rd, alloc_fu, commit_en, commit_id
  );

  modport store (
    input  alloc_en, alloc_id, alloc_rd, alloc_fu, commit_en, commit_id
  );

endinterface

/* hw/sb_pkg.sv */
/*
  scoreboard bookkeeping types
  the transaction ID is the entry index, so it is log2 of the depth wide
*/
`include "sb_consts.svh"

package sb_pkg;

  import isa_pkg::*;

  // entry index, handed out as transaction ID at issue
  typedef logic [$clog2(`SB_NR_ENTRIES)-1:0] trans_id_t;

  // --------------------
  // entry record
  // --------------------
  // issued marks a live entry
  // done marks a live entry whose result is present
  typedef struct packed {
    logic      issued;
    logic      done;
    reg_addr_t rd;
    fu_t       fu;
    xlen_t     result;
  } sb_entry_t;

endpackage

/* hw/isa_pkg.sv */
/*
  architectural types seen by the scoreboard
  only the general register file exists, there is no floating-point file
*/
`include "sb_consts.svh"

package isa_pkg;

  // register index, x0 is hardwired to zero
  typedef logic [`SB_REG_ADDR_BITS-1:0] reg_addr_t;

  // one data word
  typedef logic [`SB_XLEN-1:0] xlen_t;

  // functional unit that produces the result
  // FU_NONE means the instruction needs no unit and finishes on its own
  typedef enum logic [2:0] {
    FU_NONE = 3'd0,
    FU_ALU  = 3'd1,
    FU_MULT = 3'd2,
    FU_LOAD = 3'd3,
    FU_CSR  = 3'd4
  } fu_t;

endpackage

/* hw/sb_consts.svh */
/*
  scoreboard sizing constants
  SB_NR_ENTRIES must be a power of two, the ring pointers wrap by overflow
  the register count follows from SB_REG_ADDR_BITS
*/
`ifndef SB_CONSTS_SVH
`define SB_CONSTS_SVH

// --------------------
// scoreboard geometry
// --------------------
// number of ring entries, at most one less are ever held
`define SB_NR_ENTRIES 8

// --------------------
// architectural sizes
// --------------------
// general register index width, 32 registers
`define SB_REG_ADDR_BITS 5
// data word width
`define SB_XLEN 32

`endif
